/* tilemap_config.svh */
`ifndef TILEMAP_CONFIG_SVH
`define TILEMAP_CONFIG_SVH

////////////////////////////////////////////////////////////
// Raster geometry
////////////////////////////////////////////////////////////

`define H_TOTAL       318 // Pixel ticks per line
`define H_ACTIVE      256
`define HSYNC_START   271 // First position with sync high
`define HSYNC_END     289 // Last position with sync high
`define V_TOTAL       256 // Lines per frame
`define V_ACTIVE      240

////////////////////////////////////////////////////////////
// Host bus regions
////////////////////////////////////////////////////////////

// Bases are aligned to their sizes
`define MAP_BASE      16'h0000
`define MAP_SIZE      1024
`define GFX_BASE      16'h2000
`define GFX_SIZE      8192
`define PAL_BASE      16'h4000
`define PAL_SIZE      32   // Two bytes per palette entry

// Pixel ticks through each part of the colour path
`define BG_PIPE_DELAY 3
`define PAL_DELAY     1

`endif

/* video_pkg.sv */
package video_pkg;

  // Beam position
  typedef logic [8:0] hpos_t;      // Pixel within a line, 0 to 317
  typedef logic [7:0] vpos_t;      // Line within a frame

  // Pixel and colour values
  typedef logic [3:0] pixel_t;     // Palette index from the playfield
  typedef logic [3:0] color_t;     // One of red, green or blue

  // Tile map entry, selects 32 bytes of tile graphics
  typedef logic [7:0] tile_code_t;

endpackage

/* host_bus_pkg.sv */
package host_bus_pkg;

  // Host write bus
  typedef logic [15:0] bus_addr_t;  // Byte address
  typedef logic [7:0]  bus_data_t;  // Write data byte

  // Palette entry select, taken from address bits 4:1
  typedef logic [3:0]  pal_index_t;

endpackage

/* beam_counter.sv */
`timescale 1ns/1ps

`include "tilemap_config.svh"

module beam_counter (
  input  logic             clk_sys,
  input  logic             rst,
  input  logic             pix_ce,
  output video_pkg::hpos_t hpos,
  output video_pkg::vpos_t vpos,
  output logic             hblank,
  output logic             vblank,
  output logic             hsync
);

  import video_pkg::*;

  hpos_t hpos_next;
  vpos_t vpos_next;
  logic  line_end;

  assign line_end  = (hpos == hpos_t'(`H_TOTAL - 1));
  assign hpos_next = line_end ? '0 : hpos + 9'd1;

  // Line count moves only on the last pixel of a line
  always_comb begin
    vpos_next = vpos;
    if (line_end) begin
      if (vpos == vpos_t'(`V_TOTAL - 1)) begin
        vpos_next = '0;
      end else begin
        vpos_next = vpos + 8'd1;
      end
    end
  end

  // Flags come from the next count so they change together with it
  always_ff @(posedge clk_sys) begin
    if (rst) begin
      hpos   <= '0;
      vpos   <= '0;
      hblank <= 1'b0;
      vblank <= 1'b0;
      hsync  <= 1'b0;
    end else if (pix_ce) begin
      hpos   <= hpos_next;
      vpos   <= vpos_next;
      hblank <= (hpos_next >= hpos_t'(`H_ACTIVE));
      vblank <= (vpos_next >= vpos_t'(`V_ACTIVE));
      hsync  <= (hpos_next >= hpos_t'(`HSYNC_START)) &&
                (hpos_next <= hpos_t'(`HSYNC_END)); // Inside the hblank window
    end
  end

endmodule

/* bg_playfield.sv */
`timescale 1ns/1ps

`include "tilemap_config.svh"

module bg_playfield (
  input  logic                    clk_sys,
  input  logic                    rst,
  input  logic                    pix_ce,
  input  video_pkg::hpos_t        hpos,
  input  video_pkg::vpos_t        vpos,
  input  logic                    vblank,
  input  logic                    bus_valid,
  output logic                    bus_ready,
  input  host_bus_pkg::bus_addr_t bus_addr,
  input  host_bus_pkg::bus_data_t bus_data,
  output logic                    pal_we,
  output host_bus_pkg::pal_index_t pal_index,
  output logic                    pal_odd,
  output host_bus_pkg::bus_data_t pal_data,
  output video_pkg::pixel_t       pixel
);

  import video_pkg::*;
  import host_bus_pkg::*;

  localparam int MAP_AW = $clog2(`MAP_SIZE);
  localparam int GFX_AW = $clog2(`GFX_SIZE);

  function automatic logic in_region(bus_addr_t addr, int base, int size);
    return (int'(addr) >= base) && (int'(addr) < base + size);
  endfunction

  logic              map_sel;
  logic              gfx_sel;
  logic              pal_sel;
  logic              bus_fire;

  tile_code_t        map_mem [`MAP_SIZE];
  bus_data_t         gfx_mem [`GFX_SIZE];

  logic [MAP_AW-1:0] map_raddr;
  logic [GFX_AW-1:0] gfx_raddr;
  tile_code_t        tile_s1;   // Tile code of the position in stage 1
  logic [2:0]        row_s1;
  logic [2:0]        col_s1;
  bus_data_t         gfx_s2;    // Two pixels of the tile row
  logic              odd_s2;

  ////////////////////////////////////////////////////////////
  // Host bus decode
  ////////////////////////////////////////////////////////////

  assign map_sel = in_region(bus_addr, `MAP_BASE, `MAP_SIZE);
  assign gfx_sel = in_region(bus_addr, `GFX_BASE, `GFX_SIZE);
  assign pal_sel = in_region(bus_addr, `PAL_BASE, `PAL_SIZE);

  // Video memories hold the host off until vertical blank.
  // Palette and unmapped writes never wait.
  assign bus_ready = ~(map_sel | gfx_sel) | vblank;
  assign bus_fire  = bus_valid & bus_ready;

  assign pal_we    = bus_fire & pal_sel;
  assign pal_index = bus_addr[4:1];  // Entry select
  assign pal_odd   = bus_addr[0];    // Red byte when set
  assign pal_data  = bus_data;

  // Region bases are size aligned, low bits are the offset
  always_ff @(posedge clk_sys) begin
    if (bus_fire && map_sel) begin
      map_mem[bus_addr[MAP_AW-1:0]] <= bus_data;
    end
    if (bus_fire && gfx_sel) begin
      gfx_mem[bus_addr[GFX_AW-1:0]] <= bus_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pixel fetch
  ////////////////////////////////////////////////////////////

  // 32x32 map, one byte per 8x8 tile
  assign map_raddr = {vpos[7:3], hpos[7:3]};

  // 32 bytes per tile, 4 bytes per row, two pixels per byte
  assign gfx_raddr = {tile_s1, row_s1, col_s1[2:1]};

  always_ff @(posedge clk_sys) begin
    if (pix_ce) begin
      tile_s1 <= map_mem[map_raddr];  // Stage 1
      gfx_s2  <= gfx_mem[gfx_raddr];  // Stage 2
    end
  end

  // Position bits travel alongside the memory reads
  always_ff @(posedge clk_sys) begin
    if (rst) begin
      row_s1 <= '0;
      col_s1 <= '0;
      odd_s2 <= 1'b0;
      pixel  <= '0;
    end else if (pix_ce) begin
      row_s1 <= vpos[2:0];
      col_s1 <= hpos[2:0];
      odd_s2 <= col_s1[0];
      // Stage 3, left pixel sits in the high nibble
      pixel  <= odd_s2 ? gfx_s2[3:0] : gfx_s2[7:4];
    end
  end

endmodule

/* palette_channel.sv */
`timescale 1ns/1ps

`include "tilemap_config.svh"

module palette_channel #(
  parameter int CHANNEL = 0  // 0 red, 1 green, 2 blue
) (
  input  logic                     clk_sys,
  input  logic                     pix_ce,
  input  logic                     pal_we,
  input  host_bus_pkg::pal_index_t pal_index,
  input  logic                     pal_odd,
  input  host_bus_pkg::bus_data_t  pal_data,
  input  video_pkg::pixel_t        pixel,
  output video_pkg::color_t        color
);

  import video_pkg::*;

  localparam int   ENTRIES  = `PAL_SIZE / 2;
  localparam logic WANT_ODD = (CHANNEL == 0);  // Red lives in the odd byte
  localparam logic HIGH_NIB = (CHANNEL == 1);  // Green shares the even byte with blue

  color_t pal_mem [ENTRIES];
  logic   wr_hit;
  color_t wr_value;

  assign wr_hit   = pal_we && (pal_odd == WANT_ODD);
  assign wr_value = HIGH_NIB ? pal_data[7:4] : pal_data[3:0];

  always_ff @(posedge clk_sys) begin
    if (wr_hit) begin
      pal_mem[pal_index] <= wr_value;
    end
  end

  // One tick lookup
  always_ff @(posedge clk_sys) begin
    if (pix_ce) begin
      color <= pal_mem[pixel];
    end
  end

endmodule

/* video_out.sv */
`timescale 1ns/1ps

`include "tilemap_config.svh"

module video_out (
  input  logic              clk_sys,
  input  logic              rst,
  input  logic              pix_ce,
  input  logic              hblank_in,
  input  logic              vblank_in,
  input  logic              hsync_in,
  input  video_pkg::color_t red_in,
  input  video_pkg::color_t green_in,
  input  video_pkg::color_t blue_in,
  output video_pkg::color_t red,
  output video_pkg::color_t green,
  output video_pkg::color_t blue,
  output logic              hblank,
  output logic              vblank,
  output logic              hsync
);

  // Colour arrives this many ticks behind the beam flags
  localparam int DEPTH = `BG_PIPE_DELAY + `PAL_DELAY;

  logic [DEPTH-1:0] hblank_dly;
  logic [DEPTH-1:0] vblank_dly;
  logic [DEPTH-1:0] hsync_dly;
  logic             blank;

  assign blank = hblank_dly[DEPTH-1] | vblank_dly[DEPTH-1];

  always_ff @(posedge clk_sys) begin
    if (rst) begin
      hblank_dly <= '0;
      vblank_dly <= '0;
      hsync_dly  <= '0;
      hblank     <= 1'b0;
      vblank     <= 1'b0;
      hsync      <= 1'b0;
      red        <= '0;
      green      <= '0;
      blue       <= '0;
    end else if (pix_ce) begin
      hblank_dly <= {hblank_dly[DEPTH-2:0], hblank_in};
      vblank_dly <= {vblank_dly[DEPTH-2:0], vblank_in};
      hsync_dly  <= {hsync_dly[DEPTH-2:0], hsync_in};
      hblank     <= hblank_dly[DEPTH-1];
      vblank     <= vblank_dly[DEPTH-1];
      hsync      <= hsync_dly[DEPTH-1];
      red        <= blank ? '0 : red_in;    // Black outside the visible area
      green      <= blank ? '0 : green_in;
      blue       <= blank ? '0 : blue_in;
    end
  end

endmodule

/* tilemap_video_top.sv */
`timescale 1ns/1ps

module tilemap_video_top (
  input  logic                    clk_sys,
  input  logic                    rst,
  input  logic                    pix_ce,
  input  logic                    bus_valid,
  output logic                    bus_ready,
  input  host_bus_pkg::bus_addr_t bus_addr,
  input  host_bus_pkg::bus_data_t bus_data,
  output video_pkg::color_t       red,
  output video_pkg::color_t       green,
  output video_pkg::color_t       blue,
  output logic                    hsync,
  output logic                    hblank,
  output logic                    vblank
);

  import video_pkg::*;
  import host_bus_pkg::*;

  localparam int NUM_CHANNELS = 3;  // Red, green, blue

  hpos_t      hpos;
  vpos_t      vpos;
  logic       beam_hblank;
  logic       beam_vblank;
  logic       beam_hsync;
  logic       pal_we;
  pal_index_t pal_index;
  logic       pal_odd;
  bus_data_t  pal_data;
  pixel_t     pixel;
  color_t     chan_color [NUM_CHANNELS];

  beam_counter u_beam (
    .clk_sys (clk_sys),
    .rst     (rst),
    .pix_ce  (pix_ce),
    .hpos    (hpos),
    .vpos    (vpos),
    .hblank  (beam_hblank),
    .vblank  (beam_vblank),
    .hsync   (beam_hsync)
  );

  bg_playfield u_playfield (
    .clk_sys   (clk_sys),
    .rst       (rst),
    .pix_ce    (pix_ce),
    .hpos      (hpos),
    .vpos      (vpos),
    .vblank    (beam_vblank),  // Gates host access to the video memories
    .bus_valid (bus_valid),
    .bus_ready (bus_ready),
    .bus_addr  (bus_addr),
    .bus_data  (bus_data),
    .pal_we    (pal_we),
    .pal_index (pal_index),
    .pal_odd   (pal_odd),
    .pal_data  (pal_data),
    .pixel     (pixel)
  );

  ////////////////////////////////////////////////////////////
  // Palette, one channel per colour
  ////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_palette
    palette_channel #(
      .CHANNEL (ch)
    ) u_palette (
      .clk_sys   (clk_sys),
      .pix_ce    (pix_ce),
      .pal_we    (pal_we),
      .pal_index (pal_index),
      .pal_odd   (pal_odd),
      .pal_data  (pal_data),
      .pixel     (pixel),
      .color     (chan_color[ch])
    );
  end

  video_out u_out (
    .clk_sys   (clk_sys),
    .rst       (rst),
    .pix_ce    (pix_ce),
    .hblank_in (beam_hblank),
    .vblank_in (beam_vblank),
    .hsync_in  (beam_hsync),
    .red_in    (chan_color[0]),
    .green_in  (chan_color[1]),
    .blue_in   (chan_color[2]),
    .red       (red),
    .green     (green),
    .blue      (blue),
    .hblank    (hblank),
    .vblank    (vblank),
    .hsync     (hsync)
  );

endmodule

/* tb_tilemap_video.sv */
`timescale 1ns/1ps

`include "tilemap_config.svh"

module tb_tilemap_video;

  import video_pkg::*;
  import host_bus_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int OUT_DELAY    = `BG_PIPE_DELAY + `PAL_DELAY + 1;  // Beam flag to output
  localparam int ACTIVE_PIX   = `H_ACTIVE * `V_ACTIVE;
  localparam int WATCHDOG_NS  = 14 * `H_TOTAL * `V_TOTAL * 8;  // 14 frames

  logic        clk_sys;
  logic        rst;
  logic        pix_ce;
  logic        bus_valid;
  logic        bus_ready;
  bus_addr_t   bus_addr;
  bus_data_t   bus_data;
  color_t      red;
  color_t      green;
  color_t      blue;
  logic        hsync;
  logic        hblank;
  logic        vblank;

  logic [31:0] lfsr_state = 32'h0b0a_c3f1;
  string       test_name = "reset";

  // Expected memory contents
  bus_data_t   map_model [`MAP_SIZE];
  bus_data_t   gfx_model [`GFX_SIZE];
  color_t      pal_r [16];
  color_t      pal_g [16];
  color_t      pal_b [16];

  // Output monitor state
  logic        ce_next = 1'b0;
  logic        hb_prev;
  logic        vb_prev;
  logic        hs_prev;
  logic        h_seen;
  logic        v_seen;
  logic        pos_valid;
  logic        check_colour = 1'b0;
  logic        arm_request = 1'b0;
  int          tick_count = 0;
  int          line_ticks;
  int          low_ticks;
  int          sync_ticks;
  int          frame_lines;
  int          vb_lines;
  int          x_pos = 0;
  int          line_no = 0;
  int          active_count = 0;
  int          frames_seen = 0;
  int          frames_checked = 0;
  int          vrise_count = 0;
  int          vrise_tick = 0;

  tilemap_video_top u_dut (
    .clk_sys   (clk_sys),
    .rst       (rst),
    .pix_ce    (pix_ce),
    .bus_valid (bus_valid),
    .bus_ready (bus_ready),
    .bus_addr  (bus_addr),
    .bus_data  (bus_data),
    .red       (red),
    .green     (green),
    .blue      (blue),
    .hsync     (hsync),
    .hblank    (hblank),
    .vblank    (vblank)
  );

  initial begin
    clk_sys = 1'b0;
    forever #2 clk_sys = ~clk_sys;
  end

  always @(posedge clk_sys) begin
    pix_ce <= ~pix_ce;  // Pixel tick every second cycle
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout, the test sequence did not finish within %0d ns", WATCHDOG_NS);
    end_in_failure();
  end

  ////////////////////////////////////////////////////////////
  // Reporting and random numbers
  ////////////////////////////////////////////////////////////

  task automatic end_in_failure();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic fail_check(string name, logic [31:0] expected, logic [31:0] actual);
    $display("ERR %s expected %0d actual %0d", name, expected, actual);
    end_in_failure();
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Host bus
  ////////////////////////////////////////////////////////////

  task automatic bus_write(input bus_addr_t addr, input bus_data_t data, output int waits);
    logic [31:0] gap;
    draw_bits(1, gap);
    repeat (gap) @(posedge clk_sys);
    @(posedge clk_sys);
    bus_valid <= 1'b1;
    bus_addr  <= addr;
    bus_data  <= data;
    waits = 0;
    @(negedge clk_sys);
    while (!bus_ready) begin
      waits++;
      @(negedge clk_sys);
    end
    @(posedge clk_sys);  // Write accepted on this edge
    bus_valid <= 1'b0;
  endtask

  task automatic write_map(int offset, bus_data_t data);
    int waits;
    bus_write(bus_addr_t'(`MAP_BASE + offset), data, waits);
    map_model[offset] = data;
  endtask

  task automatic write_gfx(int offset, bus_data_t data);
    int waits;
    bus_write(bus_addr_t'(`GFX_BASE + offset), data, waits);
    gfx_model[offset] = data;
  endtask

  task automatic write_palette(int entry, color_t r, color_t g, color_t b);
    int waits;
    bus_write(bus_addr_t'(`PAL_BASE + 2 * entry), {g, b}, waits);
    assert (waits == 0) else fail_check("palette_ready", 0, waits);
    bus_write(bus_addr_t'(`PAL_BASE + 2 * entry + 1), {4'h0, r}, waits);
    assert (waits == 0) else fail_check("palette_ready", 0, waits);
    pal_r[entry] = r;
    pal_g[entry] = g;
    pal_b[entry] = b;
  endtask

  ////////////////////////////////////////////////////////////
  // Expected picture and frame checking
  ////////////////////////////////////////////////////////////

  function automatic int expected_pixel(int x, int y);
    bus_data_t tile;
    bus_data_t row_byte;
    tile     = map_model[(y / 8) * 32 + x / 8];
    row_byte = gfx_model[int'(tile) * 32 + (y % 8) * 4 + (x % 8) / 2];
    return (x % 2 == 0) ? int'(row_byte[7:4]) : int'(row_byte[3:0]);  // Left pixel high
  endfunction

  task automatic stop_checks();
    check_colour = 1'b0;
    arm_request  = 1'b0;
  endtask

  // Checks start at the next frame and stay on after it
  task automatic check_next_frame();
    int count0;
    count0      = frames_checked;
    arm_request = 1'b1;
    wait (frames_checked == count0 + 1);
  endtask

  always @(negedge clk_sys) begin
    logic hrise;
    logic hfall;
    logic vrise;
    logic vfall;
    int   idx;
    hrise = hblank && !hb_prev;
    hfall = !hblank && hb_prev;
    vrise = vblank && !vb_prev;
    vfall = !vblank && vb_prev;
    if (rst) begin
      hb_prev     = 1'b0;
      vb_prev     = 1'b0;
      hs_prev     = 1'b0;
      h_seen      = 1'b0;
      v_seen      = 1'b0;
      pos_valid   = 1'b0;
      line_ticks  = 0;
      low_ticks   = 0;
      sync_ticks  = 0;
      frame_lines = 0;
      vb_lines    = 0;
    end else if (ce_next) begin
      tick_count++;
      line_ticks++;
      if (!hblank) low_ticks++;
      if (hsync) sync_ticks++;
      if (hrise) begin
        if (h_seen) begin
          assert (line_ticks == `H_TOTAL) else fail_check("raster_line", `H_TOTAL, line_ticks);
          assert (low_ticks == `H_ACTIVE) else fail_check("raster_active", `H_ACTIVE, low_ticks);
        end
        h_seen     = 1'b1;
        line_ticks = 0;
        low_ticks  = 0;
        frame_lines++;
        if (vblank) vb_lines++;
      end
      if (hsync && !hs_prev && h_seen) begin
        assert (line_ticks == `HSYNC_START - `H_ACTIVE)
          else fail_check("raster_sync_start", `HSYNC_START - `H_ACTIVE, line_ticks);
      end
      if (!hsync && hs_prev) begin
        assert (sync_ticks == `HSYNC_END - `HSYNC_START + 1)
          else fail_check("raster_sync_width", `HSYNC_END - `HSYNC_START + 1, sync_ticks);
        sync_ticks = 0;
      end
      if (vrise) begin
        if (v_seen) begin
          assert (frame_lines == `V_TOTAL) else fail_check("raster_frame", `V_TOTAL, frame_lines);
          frames_seen++;
        end
        if (check_colour) begin
          assert (active_count == ACTIVE_PIX) else fail_check(test_name, ACTIVE_PIX, active_count);
          frames_checked++;
        end
        v_seen      = 1'b1;
        frame_lines = 0;
        vb_lines    = 0;
        vrise_count++;
        vrise_tick  = tick_count;
      end
      // Position restarts on the falling blank edges
      if (vfall) begin
        assert (vb_lines == `V_TOTAL - `V_ACTIVE)
          else fail_check("raster_vblank", `V_TOTAL - `V_ACTIVE, vb_lines);
        pos_valid    = 1'b1;
        line_no      = 0;
        active_count = 0;
        if (arm_request) check_colour = 1'b1;
      end else if (hfall) begin
        line_no++;
      end
      x_pos = hfall ? 0 : x_pos + 1;
      if (hblank || vblank) begin
        assert ({red, green, blue} === 12'h000) else fail_check("blanking", 0, {red, green, blue});
      end else if (check_colour) begin
        idx = expected_pixel(x_pos, line_no);
        assert (red === pal_r[idx]) else fail_check({test_name, " red"}, pal_r[idx], red);
        assert (green === pal_g[idx]) else fail_check({test_name, " green"}, pal_g[idx], green);
        assert (blue === pal_b[idx]) else fail_check({test_name, " blue"}, pal_b[idx], blue);
        active_count++;
      end
      hb_prev = hblank;
      vb_prev = vblank;
      hs_prev = hsync;
    end
    ce_next = pix_ce;  // Next rising edge is a pixel tick
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          waits;
    int          t0;
    int          count0;
    logic [31:0] rnd;
    logic [11:0] used [16];
    logic        dup;
    color_t      new_red;
    bus_data_t   tile0_row [4];
    rst       = 1'b1;
    pix_ce    = 1'b0;
    bus_valid = 1'b0;
    bus_addr  = '0;
    bus_data  = '0;
    tile0_row = '{8'h12, 8'h34, 8'h56, 8'h78};

    repeat (RESET_CYCLES - 1) begin
      @(negedge clk_sys);
      assert ({red, green, blue, hsync, hblank, vblank} === 15'h0)
        else fail_check("reset", 0, {red, green, blue, hsync, hblank, vblank});
    end
    @(posedge clk_sys);
    rst <= 1'b0;

    test_name = "raster";
    wait (frames_seen >= 1);

    // Host held off from the video memories until vertical blank
    test_name = "wait_rule";
    wait (pos_valid && line_no == 8);
    write_palette(0, 4'h0, 4'h0, 4'h0);
    count0 = vrise_count;
    bus_write(bus_addr_t'(`MAP_BASE), 8'h00, waits);
    t0 = tick_count;
    assert (waits > 0) else begin
      $display("Map write during active display was not held off by bus_ready");
      end_in_failure();
    end
    wait (vrise_count == count0 + 1);
    assert (vrise_tick - t0 == OUT_DELAY) else fail_check(test_name, OUT_DELAY, vrise_tick - t0);

    test_name = "fill";
    for (int i = 0; i < `GFX_SIZE; i++) begin
      write_gfx(i, 8'h55);
    end
    for (int i = 0; i < `MAP_SIZE; i++) begin
      write_map(i, 8'h00);
    end
    draw_bits(12, rnd);
    write_palette(5, rnd[11:8], rnd[7:4], rnd[3:0]);
    check_next_frame();

    stop_checks();
    test_name = "pattern";
    for (int i = 0; i < 32; i++) begin
      write_gfx(i, tile0_row[i % 4]);
      write_gfx(32 + i, 8'hFF);
    end
    for (int i = 0; i < `MAP_SIZE; i++) begin
      write_map(i, bus_data_t'(i % 2));  // Tiles 0 and 1 by column
    end
    for (int e = 0; e < 16; e++) begin
      do begin
        draw_bits(12, rnd);
        dup = 1'b0;
        for (int k = 0; k < e; k++) begin
          if (used[k] == rnd[11:0]) dup = 1'b1;
        end
      end while (dup);
      used[e] = rnd[11:0];
      write_palette(e, rnd[11:8], rnd[7:4], rnd[3:0]);
    end
    check_next_frame();

    // New red for entry 3 in the middle of a frame
    test_name = "rewrite";
    wait (pos_valid && line_no == 100);
    stop_checks();
    draw_bits(4, rnd);
    new_red = pal_r[3] ^ (rnd[3:0] | 4'h1);
    bus_write(bus_addr_t'(`PAL_BASE + 7), {4'h0, new_red}, waits);
    assert (waits == 0) else fail_check("palette_ready", 0, waits);
    pal_r[3] = new_red;
    check_next_frame();

    if (frames_checked == 3) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Expected 3 checked frames but saw %0d", frames_checked);
      end_in_failure();
    end
  end

endmodule

/* build.f */
+incdir+.
video_pkg.sv
host_bus_pkg.sv
beam_counter.sv
bg_playfield.sv
palette_channel.sv
video_out.sv
tilemap_video_top.sv
tb_tilemap_video.sv
